// ==== design/csr_pkg.sv ====
package csr_pkg;

    localparam int CSR_NUM_W = 14;

    // operations issued by the pipeline
    typedef enum logic [2:0] {
        OP_NONE,
        OP_CSRRD,
        OP_CSRWR,
        OP_CSRXCHG,
        OP_ERTN
    } csr_op_e;

    // update applied to the register file in one cycle
    typedef enum logic [1:0] {
        UPD_NONE,
        UPD_WRITE,
        UPD_TRAP,
        UPD_ERTN
    } upd_kind_e;

    localparam logic [CSR_NUM_W-1:0] CSR_CRMD   = 14'h000;
    localparam logic [CSR_NUM_W-1:0] CSR_PRMD   = 14'h001;
    localparam logic [CSR_NUM_W-1:0] CSR_ECFG   = 14'h004;
    localparam logic [CSR_NUM_W-1:0] CSR_ESTAT  = 14'h005;
    localparam logic [CSR_NUM_W-1:0] CSR_ERA    = 14'h006;
    localparam logic [CSR_NUM_W-1:0] CSR_BADV   = 14'h007;
    localparam logic [CSR_NUM_W-1:0] CSR_EENTRY = 14'h00c;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE0  = 14'h030;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE1  = 14'h031;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE2  = 14'h032;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE3  = 14'h033;
    localparam logic [CSR_NUM_W-1:0] CSR_TID    = 14'h040;
    localparam logic [CSR_NUM_W-1:0] CSR_TCFG   = 14'h041;
    localparam logic [CSR_NUM_W-1:0] CSR_TVAL   = 14'h042;
    localparam logic [CSR_NUM_W-1:0] CSR_TICLR  = 14'h044;

    localparam logic [5:0] ECODE_INT = 6'h00;
    localparam logic [5:0] ECODE_ADE = 6'h08;
    localparam logic [5:0] ECODE_SYS = 6'h0b;
    localparam logic [5:0] ECODE_BRK = 6'h0c;
    localparam logic [5:0] ECODE_INE = 6'h0d;

    // DA set, PLV 0, interrupts off
    localparam logic [8:0] CRMD_RESET = 9'h008;

endpackage

// ==== design/csr_regfile.sv ====
module csr_regfile #(
    parameter int TIMER_W = 20
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  csr_pkg::upd_kind_e            upd_kind,
    input  logic [csr_pkg::CSR_NUM_W-1:0] upd_num,
    input  logic [31:0]                   upd_data,
    input  logic [5:0]                    upd_ecode,
    input  logic [8:0]                    upd_esubcode,
    input  logic [31:0]                   upd_era,
    input  logic [31:0]                   upd_badv,
    input  logic [csr_pkg::CSR_NUM_W-1:0] rd_num,
    input  logic [TIMER_W-1:0]            tcfg,
    input  logic [TIMER_W-1:0]            tval,
    input  logic                          ti_flag,
    output logic [31:0]                   rd_data,
    output logic [8:0]                    crmd,
    output logic [2:0]                    prmd,
    output logic [12:0]                   ecfg_lie,
    output logic [1:0]                    estat_is,
    output logic [31:0]                   era,
    output logic [31:0]                   eentry
);

    logic [5:0]  estat_ecode;
    logic [8:0]  estat_esubcode;
    logic [31:0] badv;
    logic [25:0] eentry_va;
    logic [31:0] save [4];
    logic [31:0] tid;

    assign eentry = {eentry_va, 6'b0};

    always_comb
    begin
        rd_data = '0;
        case (rd_num)
            csr_pkg::CSR_CRMD:   rd_data = {23'b0, crmd};
            csr_pkg::CSR_PRMD:   rd_data = {29'b0, prmd};
            csr_pkg::CSR_ECFG:   rd_data = {19'b0, ecfg_lie};
            // hardware lines are not latched here
            csr_pkg::CSR_ESTAT:  rd_data = {1'b0, estat_esubcode, estat_ecode, 4'b0,
                                            ti_flag, 9'b0, estat_is};
            csr_pkg::CSR_ERA:    rd_data = era;
            csr_pkg::CSR_BADV:   rd_data = badv;
            csr_pkg::CSR_EENTRY: rd_data = eentry;
            csr_pkg::CSR_SAVE0,
            csr_pkg::CSR_SAVE1,
            csr_pkg::CSR_SAVE2,
            csr_pkg::CSR_SAVE3:  rd_data = save[rd_num[1:0]];
            csr_pkg::CSR_TID:    rd_data = tid;
            csr_pkg::CSR_TCFG:   rd_data = {{(32-TIMER_W){1'b0}}, tcfg};
            csr_pkg::CSR_TVAL:   rd_data = {{(32-TIMER_W){1'b0}}, tval};
            default:             rd_data = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd           <= csr_pkg::CRMD_RESET;
            prmd           <= '0;
            ecfg_lie       <= '0;
            estat_is       <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era            <= '0;
            badv           <= '0;
            eentry_va      <= '0;
            save           <= '{default: '0};
            tid            <= '0;
        end
        else
        begin
            case (upd_kind)
                csr_pkg::UPD_WRITE:
                begin
                    case (upd_num)
                        csr_pkg::CSR_CRMD:
                        begin
                            crmd[2:0] <= upd_data[2:0];
                            crmd[8:5] <= upd_data[8:5];
                            // pg and da must stay exclusive
                            if (upd_data[4] ^ upd_data[3])
                                crmd[4:3] <= upd_data[4:3];
                        end
                        csr_pkg::CSR_PRMD:   prmd <= upd_data[2:0];
                        csr_pkg::CSR_ECFG:   ecfg_lie <= {upd_data[12:11], 1'b0, upd_data[9:0]};
                        csr_pkg::CSR_ESTAT:  estat_is <= upd_data[1:0];
                        csr_pkg::CSR_ERA:    era <= upd_data;
                        csr_pkg::CSR_BADV:   badv <= upd_data;
                        csr_pkg::CSR_EENTRY: eentry_va <= upd_data[31:6];
                        csr_pkg::CSR_SAVE0,
                        csr_pkg::CSR_SAVE1,
                        csr_pkg::CSR_SAVE2,
                        csr_pkg::CSR_SAVE3:  save[upd_num[1:0]] <= upd_data;
                        csr_pkg::CSR_TID:    tid <= upd_data;
                        default:             ;
                    endcase
                end
                csr_pkg::UPD_TRAP:
                begin
                    prmd           <= crmd[2:0];
                    crmd[2:0]      <= 3'b0;
                    era            <= upd_era;
                    estat_ecode    <= upd_ecode;
                    estat_esubcode <= upd_esubcode;
                    // interrupts leave badv alone
                    if (upd_ecode != csr_pkg::ECODE_INT)
                        badv <= upd_badv;
                end
                csr_pkg::UPD_ERTN:
                begin
                    crmd[2:0] <= prmd;
                end
                default:
                begin
                end
            endcase
        end
    end

endmodule

// ==== design/csr_write_arbiter.sv ====
module csr_write_arbiter (
    input  logic                          trap_req,
    input  logic                          ertn_req,
    input  logic                          wr_req,
    input  logic [5:0]                    t_ecode,
    input  logic [8:0]                    t_esubcode,
    input  logic [31:0]                   t_era,
    input  logic [31:0]                   t_badv,
    input  logic [csr_pkg::CSR_NUM_W-1:0] wr_num,
    input  logic [31:0]                   wr_data,
    output csr_pkg::upd_kind_e            upd_kind,
    output logic [csr_pkg::CSR_NUM_W-1:0] upd_num,
    output logic [31:0]                   upd_data,
    output logic [5:0]                    upd_ecode,
    output logic [8:0]                    upd_esubcode,
    output logic [31:0]                   upd_era,
    output logic [31:0]                   upd_badv
);

    always_comb
    begin
        upd_kind     = csr_pkg::UPD_NONE;
        upd_num      = '0;
        upd_data     = '0;
        upd_ecode    = '0;
        upd_esubcode = '0;
        upd_era      = '0;
        upd_badv     = '0;
        // trap beats ertn beats csr write
        if (trap_req)
        begin
            upd_kind     = csr_pkg::UPD_TRAP;
            upd_ecode    = t_ecode;
            upd_esubcode = t_esubcode;
            upd_era      = t_era;
            upd_badv     = t_badv;
        end
        else if (ertn_req)
        begin
            upd_kind = csr_pkg::UPD_ERTN;
        end
        else if (wr_req)
        begin
            upd_kind = csr_pkg::UPD_WRITE;
            upd_num  = wr_num;
            upd_data = wr_data;
        end
    end

endmodule

// ==== design/csr_access_unit.sv ====
module csr_access_unit (
    input  logic                          op_valid,
    input  csr_pkg::csr_op_e              op,
    input  logic [csr_pkg::CSR_NUM_W-1:0] csr_num,
    input  logic [31:0]                   wdata,
    input  logic [31:0]                   wmask,
    input  logic [31:0]                   rd_data,
    output logic [csr_pkg::CSR_NUM_W-1:0] rd_num,
    output logic [31:0]                   rdata,
    output logic                          wr_req,
    output logic [csr_pkg::CSR_NUM_W-1:0] wr_num,
    output logic [31:0]                   wr_data
);

    logic is_rd;
    logic is_wr;
    logic is_xchg;

    assign is_rd   = op_valid && (op == csr_pkg::OP_CSRRD);
    assign is_wr   = op_valid && (op == csr_pkg::OP_CSRWR);
    assign is_xchg = op_valid && (op == csr_pkg::OP_CSRXCHG);

    assign rd_num = csr_num;

    // every csr instruction returns the old value
    assign rdata = (is_rd || is_wr || is_xchg) ? rd_data : 32'b0;

    assign wr_req = is_wr || is_xchg;
    assign wr_num = csr_num;

    // mask bits pick wdata, others keep old value
    always_comb
    begin
        if (is_xchg)
            wr_data = (rd_data & ~wmask) | (wdata & wmask);
        else
            wr_data = wdata;
    end

endmodule

// ==== design/excp_unit.sv ====
module excp_unit (
    input  logic             op_valid,
    input  csr_pkg::csr_op_e op,
    input  logic             excp_valid,
    input  logic [5:0]       ecode,
    input  logic [8:0]       esubcode,
    input  logic [31:0]      excp_pc,
    input  logic [31:0]      excp_badv,
    input  logic [31:0]      pc_next,
    input  logic [7:0]       hw_irq,
    input  logic             ti_flag,
    input  logic             crmd_ie,
    input  logic [12:0]      ecfg_lie,
    input  logic [1:0]       estat_is,
    input  logic [31:0]      era,
    input  logic [31:0]      eentry,
    output logic             trap_req,
    output logic             ertn_req,
    output logic [5:0]       t_ecode,
    output logic [8:0]       t_esubcode,
    output logic [31:0]      t_era,
    output logic [31:0]      t_badv,
    output logic             flush,
    output logic [31:0]      redirect_pc
);

    logic [12:0] int_vec;
    logic        take_int;

    // same bit layout as estat.is without the ipi source
    assign int_vec  = {1'b0, ti_flag, 1'b0, hw_irq, estat_is} & ecfg_lie;
    assign take_int = crmd_ie && (|int_vec);

    assign trap_req = take_int || excp_valid;
    assign ertn_req = op_valid && (op == csr_pkg::OP_ERTN);
    assign flush    = trap_req || ertn_req;

    always_comb
    begin
        t_ecode    = ecode;
        t_esubcode = esubcode;
        t_era      = excp_pc;
        t_badv     = excp_badv;
        if (take_int)
        begin
            t_ecode    = csr_pkg::ECODE_INT;
            t_esubcode = '0;
            t_era      = pc_next;
            t_badv     = '0;
        end
        else if (ecode == csr_pkg::ECODE_ADE && esubcode == 9'd0)
        begin
            // bad fetch address is the pc itself
            t_badv = excp_pc;
        end
    end

    always_comb
    begin
        if (trap_req)
            redirect_pc = eentry;
        else if (ertn_req)
            redirect_pc = era;
        else
            redirect_pc = '0;
    end

endmodule

// ==== design/csr_timer.sv ====
module csr_timer #(
    parameter int TIMER_W = 20
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  csr_pkg::upd_kind_e            upd_kind,
    input  logic [csr_pkg::CSR_NUM_W-1:0] upd_num,
    input  logic [31:0]                   upd_data,
    output logic [TIMER_W-1:0]            tcfg,
    output logic [TIMER_W-1:0]            tval,
    output logic                          ti_flag
);

    logic cfg_wr;
    logic clr_wr;
    logic en;
    logic periodic;

    assign cfg_wr = (upd_kind == csr_pkg::UPD_WRITE) && (upd_num == csr_pkg::CSR_TCFG);
    assign clr_wr = (upd_kind == csr_pkg::UPD_WRITE) && (upd_num == csr_pkg::CSR_TICLR)
                    && upd_data[0];

    assign en       = tcfg[0];
    assign periodic = tcfg[1];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg    <= '0;
            tval    <= '0;
            ti_flag <= 1'b0;
        end
        else
        begin
            // initval sits in tcfg above en and periodic
            if (cfg_wr)
            begin
                tcfg <= upd_data[TIMER_W-1:0];
                tval <= {upd_data[TIMER_W-1:2], 2'b00};
            end
            else if (en && tval != '0)
                tval <= tval - 1'b1;
            else if (en && periodic)
                tval <= {tcfg[TIMER_W-1:2], 2'b00};

            if (clr_wr)
                ti_flag <= 1'b0;
            else if (en && tval == TIMER_W'(1))
                ti_flag <= 1'b1;
        end
    end

endmodule

// ==== design/csr_unit.sv ====
module csr_unit #(
    parameter int TIMER_W = 20
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          op_valid,
    input  csr_pkg::csr_op_e              op,
    input  logic [csr_pkg::CSR_NUM_W-1:0] csr_num,
    input  logic [31:0]                   wdata,
    input  logic [31:0]                   wmask,
    input  logic                          excp_valid,
    input  logic [5:0]                    ecode,
    input  logic [8:0]                    esubcode,
    input  logic [31:0]                   excp_pc,
    input  logic [31:0]                   excp_badv,
    input  logic [31:0]                   pc_next,
    input  logic [7:0]                    hw_irq,
    output logic [31:0]                   rdata,
    output logic                          flush,
    output logic [31:0]                   redirect_pc,
    output logic [8:0]                    crmd
);

    logic [csr_pkg::CSR_NUM_W-1:0] rd_num;
    logic [31:0]                   rd_data;
    logic                          wr_req;
    logic [csr_pkg::CSR_NUM_W-1:0] wr_num;
    logic [31:0]                   wr_data;
    logic                          trap_req;
    logic                          ertn_req;
    logic [5:0]                    t_ecode;
    logic [8:0]                    t_esubcode;
    logic [31:0]                   t_era;
    logic [31:0]                   t_badv;
    csr_pkg::upd_kind_e            upd_kind;
    logic [csr_pkg::CSR_NUM_W-1:0] upd_num;
    logic [31:0]                   upd_data;
    logic [5:0]                    upd_ecode;
    logic [8:0]                    upd_esubcode;
    logic [31:0]                   upd_era;
    logic [31:0]                   upd_badv;
    logic [TIMER_W-1:0]            tcfg;
    logic [TIMER_W-1:0]            tval;
    logic                          ti_flag;
    logic [12:0]                   ecfg_lie;
    logic [1:0]                    estat_is;
    logic [31:0]                   era;
    logic [31:0]                   eentry;

    csr_access_unit access_unit_i (
        .op_valid (op_valid),
        .op       (op),
        .csr_num  (csr_num),
        .wdata    (wdata),
        .wmask    (wmask),
        .rd_data  (rd_data),
        .rd_num   (rd_num),
        .rdata    (rdata),
        .wr_req   (wr_req),
        .wr_num   (wr_num),
        .wr_data  (wr_data)
    );

    excp_unit excp_unit_i (
        .op_valid    (op_valid),
        .op          (op),
        .excp_valid  (excp_valid),
        .ecode       (ecode),
        .esubcode    (esubcode),
        .excp_pc     (excp_pc),
        .excp_badv   (excp_badv),
        .pc_next     (pc_next),
        .hw_irq      (hw_irq),
        .ti_flag     (ti_flag),
        .crmd_ie     (crmd[2]),
        .ecfg_lie    (ecfg_lie),
        .estat_is    (estat_is),
        .era         (era),
        .eentry      (eentry),
        .trap_req    (trap_req),
        .ertn_req    (ertn_req),
        .t_ecode     (t_ecode),
        .t_esubcode  (t_esubcode),
        .t_era       (t_era),
        .t_badv      (t_badv),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

    csr_write_arbiter write_arbiter_i (
        .trap_req     (trap_req),
        .ertn_req     (ertn_req),
        .wr_req       (wr_req),
        .t_ecode      (t_ecode),
        .t_esubcode   (t_esubcode),
        .t_era        (t_era),
        .t_badv       (t_badv),
        .wr_num       (wr_num),
        .wr_data      (wr_data),
        .upd_kind     (upd_kind),
        .upd_num      (upd_num),
        .upd_data     (upd_data),
        .upd_ecode    (upd_ecode),
        .upd_esubcode (upd_esubcode),
        .upd_era      (upd_era),
        .upd_badv     (upd_badv)
    );

    csr_timer #(
        .TIMER_W (TIMER_W)
    ) timer_i (
        .clk      (clk),
        .rstn     (rstn),
        .upd_kind (upd_kind),
        .upd_num  (upd_num),
        .upd_data (upd_data),
        .tcfg     (tcfg),
        .tval     (tval),
        .ti_flag  (ti_flag)
    );

    csr_regfile #(
        .TIMER_W (TIMER_W)
    ) regfile_i (
        .clk          (clk),
        .rstn         (rstn),
        .upd_kind     (upd_kind),
        .upd_num      (upd_num),
        .upd_data     (upd_data),
        .upd_ecode    (upd_ecode),
        .upd_esubcode (upd_esubcode),
        .upd_era      (upd_era),
        .upd_badv     (upd_badv),
        .rd_num       (rd_num),
        .tcfg         (tcfg),
        .tval         (tval),
        .ti_flag      (ti_flag),
        .rd_data      (rd_data),
        .crmd         (crmd),
        .prmd         (),
        .ecfg_lie     (ecfg_lie),
        .estat_is     (estat_is),
        .era          (era),
        .eentry       (eentry)
    );

endmodule

// ==== verification/clk_gen.sv ====
module clk_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

// ==== verification/csr_unit_tb.sv ====
module csr_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD_NS = 8;
    localparam int TIMER_W       = 20;
    localparam logic [31:0] LCG_SEED = 32'h502f_979a;

    // timer initval with en and periodic bits clear
    localparam int TIMER_COUNT = 16;
    localparam int INT_MARGIN  = 20;

    // rough cycle budget of each test
    localparam int BUDGET_CYCLES = 10 + 20 + 12 + 40 + (TIMER_COUNT + INT_MARGIN + 20) + 20;
    localparam int WATCHDOG_CYCLES = BUDGET_CYCLES + 50;

    logic                          clk;
    logic                          rstn;
    logic                          op_valid;
    csr_pkg::csr_op_e              op;
    logic [csr_pkg::CSR_NUM_W-1:0] csr_num;
    logic [31:0]                   wdata;
    logic [31:0]                   wmask;
    logic                          excp_valid;
    logic [5:0]                    ecode;
    logic [8:0]                    esubcode;
    logic [31:0]                   excp_pc;
    logic [31:0]                   excp_badv;
    logic [31:0]                   pc_next;
    logic [7:0]                    hw_irq;
    logic [31:0]                   rdata;
    logic                          flush;
    logic [31:0]                   redirect_pc;
    logic [8:0]                    crmd;

    logic [31:0] lcg_state;
    int          n_checks;
    int          n_errors;
    logic        seen_flush;
    logic [31:0] seen_redirect;

    // expected contents of save0..save3
    logic [31:0] save_model [4];
    logic [31:0] eentry_model;

    clk_gen #(
        .PERIOD_NS (CLK_PERIOD_NS)
    ) clk_gen_i (
        .clk (clk)
    );

    csr_unit #(
        .TIMER_W (TIMER_W)
    ) csr_unit_i (
        .clk         (clk),
        .rstn        (rstn),
        .op_valid    (op_valid),
        .op          (op),
        .csr_num     (csr_num),
        .wdata       (wdata),
        .wmask       (wmask),
        .excp_valid  (excp_valid),
        .ecode       (ecode),
        .esubcode    (esubcode),
        .excp_pc     (excp_pc),
        .excp_badv   (excp_badv),
        .pc_next     (pc_next),
        .hw_irq      (hw_irq),
        .rdata       (rdata),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .crmd        (crmd)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        n_checks++;
        if (actual !== expected)
        begin
            n_errors++;
            $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    // drive one op at the edge, sample outputs mid cycle, leave it on the bus
    task automatic issue_op(input csr_pkg::csr_op_e o, input logic [13:0] n,
                            input logic [31:0] d, input logic [31:0] m,
                            output logic [31:0] old);
        @(posedge clk);
        op_valid   <= 1'b1;
        op         <= o;
        csr_num    <= n;
        wdata      <= d;
        wmask      <= m;
        excp_valid <= 1'b0;
        @(negedge clk);
        old           = rdata;
        seen_flush    = flush;
        seen_redirect = redirect_pc;
    endtask

    task automatic write_csr(input logic [13:0] n, input logic [31:0] d);
        logic [31:0] unused;
        issue_op(csr_pkg::OP_CSRWR, n, d, 32'h0, unused);
    endtask

    task automatic read_csr(input logic [13:0] n, output logic [31:0] v);
        issue_op(csr_pkg::OP_CSRRD, n, 32'h0, 32'h0, v);
    endtask

    task automatic raise_excp(input logic [5:0] code, input logic [31:0] pc,
                              input logic [31:0] bad);
        @(posedge clk);
        op_valid   <= 1'b0;
        op         <= csr_pkg::OP_NONE;
        excp_valid <= 1'b1;
        ecode      <= code;
        esubcode   <= 9'h0;
        excp_pc    <= pc;
        excp_badv  <= bad;
        @(negedge clk);
        seen_flush    = flush;
        seen_redirect = redirect_pc;
    endtask

    task automatic go_idle();
        @(posedge clk);
        op_valid   <= 1'b0;
        op         <= csr_pkg::OP_NONE;
        excp_valid <= 1'b0;
        @(negedge clk);
    endtask

    task automatic check_reset_state();
        logic [31:0] v;
        check_value("reset flush", 32'h0, {31'b0, flush});
        check_value("reset crmd", {23'b0, csr_pkg::CRMD_RESET}, {23'b0, crmd});
        read_csr(csr_pkg::CSR_SAVE0, v);
        check_value("reset save0", 32'h0, v);
        go_idle();
    endtask

    task automatic write_then_read();
        logic [31:0] d;
        logic [31:0] v;
        logic [13:0] n;
        for (int i = 0; i < 4; i++)
        begin
            d = lcg_next();
            n = csr_pkg::CSR_SAVE0 + 14'(i);
            issue_op(csr_pkg::OP_CSRWR, n, d, 32'h0, v);
            check_value($sformatf("write_read save%0d old", i), save_model[i], v);
            save_model[i] = d;
            read_csr(n, v);
            check_value($sformatf("write_read save%0d new", i), d, v);
        end
        go_idle();
    endtask

    task automatic exchange_masked();
        logic [31:0] d;
        logic [31:0] m;
        logic [31:0] v;
        logic [31:0] merged;
        d = lcg_next();
        m = lcg_next();
        // a set mask bit takes the new bit
        for (int b = 0; b < 32; b++)
            merged[b] = m[b] ? d[b] : save_model[1][b];
        issue_op(csr_pkg::OP_CSRXCHG, csr_pkg::CSR_SAVE1, d, m, v);
        check_value("xchg old", save_model[1], v);
        save_model[1] = merged;
        read_csr(csr_pkg::CSR_SAVE1, v);
        check_value("xchg merged", merged, v);
        go_idle();
    endtask

    task automatic exception_and_return();
        logic [31:0] entry;
        logic [31:0] pc;
        logic [31:0] bad;
        logic [31:0] v;
        entry = lcg_next() & 32'hffff_ffc0;
        pc    = lcg_next() & 32'hffff_fffc;
        bad   = lcg_next();
        write_csr(csr_pkg::CSR_EENTRY, entry);
        eentry_model = entry;
        // plv 3, ie on, da kept
        write_csr(csr_pkg::CSR_CRMD, 32'h0000_000f);
        go_idle();
        check_value("excp crmd before", 32'h00f, {23'b0, crmd});
        raise_excp(csr_pkg::ECODE_SYS, pc, bad);
        check_value("excp flush", 32'h1, {31'b0, seen_flush});
        check_value("excp redirect", entry, seen_redirect);
        go_idle();
        check_value("excp crmd after", 32'h008, {23'b0, crmd});
        read_csr(csr_pkg::CSR_ERA, v);
        check_value("excp era", pc, v);
        read_csr(csr_pkg::CSR_ESTAT, v);
        check_value("excp ecode", {26'b0, csr_pkg::ECODE_SYS}, {26'b0, v[21:16]});
        read_csr(csr_pkg::CSR_PRMD, v);
        check_value("excp prmd", 32'h7, v);
        read_csr(csr_pkg::CSR_BADV, v);
        check_value("excp badv", bad, v);
        issue_op(csr_pkg::OP_ERTN, 14'h0, 32'h0, 32'h0, v);
        check_value("ertn flush", 32'h1, {31'b0, seen_flush});
        check_value("ertn redirect", pc, seen_redirect);
        go_idle();
        check_value("ertn crmd", 32'h00f, {23'b0, crmd});
    endtask

    task automatic timer_interrupt();
        logic [31:0] int_pc;
        logic [31:0] v;
        int          waited;
        read_csr(csr_pkg::CSR_EENTRY, v);
        check_value("timer eentry", eentry_model, v);
        int_pc = lcg_next() & 32'hffff_fffc;
        go_idle();
        @(posedge clk);
        pc_next <= int_pc;
        write_csr(csr_pkg::CSR_ECFG, 32'h0000_0800);
        // one shot, enabled
        write_csr(csr_pkg::CSR_TCFG, 32'(TIMER_COUNT) | 32'h1);
        go_idle();
        waited = 0;
        while (!flush && waited < TIMER_COUNT + INT_MARGIN)
        begin
            @(negedge clk);
            waited++;
        end
        if (!flush)
        begin
            n_errors++;
            $display("timer interrupt did not arrive within %0d cycles", waited);
        end
        else
        begin
            check_value("timer redirect", eentry_model, redirect_pc);
        end
        read_csr(csr_pkg::CSR_ESTAT, v);
        check_value("timer ecode", {26'b0, csr_pkg::ECODE_INT}, {26'b0, v[21:16]});
        check_value("timer flag set", 32'h1, {31'b0, v[11]});
        read_csr(csr_pkg::CSR_ERA, v);
        check_value("timer era", int_pc, v);
        write_csr(csr_pkg::CSR_TICLR, 32'h1);
        read_csr(csr_pkg::CSR_ESTAT, v);
        check_value("timer flag cleared", 32'h0, {31'b0, v[11]});
        go_idle();
    endtask

    task automatic trap_drops_write();
        logic [31:0] d;
        logic [31:0] pc;
        logic [31:0] v;
        d  = lcg_next();
        pc = lcg_next() & 32'hffff_fffc;
        @(posedge clk);
        op_valid   <= 1'b1;
        op         <= csr_pkg::OP_CSRWR;
        csr_num    <= csr_pkg::CSR_SAVE2;
        wdata      <= d;
        wmask      <= 32'h0;
        excp_valid <= 1'b1;
        ecode      <= csr_pkg::ECODE_BRK;
        esubcode   <= 9'h0;
        excp_pc    <= pc;
        excp_badv  <= 32'h0;
        @(negedge clk);
        check_value("arb flush", 32'h1, {31'b0, flush});
        check_value("arb old", save_model[2], rdata);
        go_idle();
        read_csr(csr_pkg::CSR_SAVE2, v);
        check_value("arb save2 kept", save_model[2], v);
        read_csr(csr_pkg::CSR_ERA, v);
        check_value("arb era", pc, v);
        read_csr(csr_pkg::CSR_ESTAT, v);
        check_value("arb ecode", {26'b0, csr_pkg::ECODE_BRK}, {26'b0, v[21:16]});
        go_idle();
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial
    begin
        lcg_state    = LCG_SEED;
        n_checks     = 0;
        n_errors     = 0;
        save_model   = '{default: 32'h0};
        eentry_model = '0;
        rstn       <= 1'b0;
        op_valid   <= 1'b0;
        op         <= csr_pkg::OP_NONE;
        csr_num    <= '0;
        wdata      <= '0;
        wmask      <= '0;
        excp_valid <= 1'b0;
        ecode      <= '0;
        esubcode   <= '0;
        excp_pc    <= '0;
        excp_badv  <= '0;
        pc_next    <= '0;
        hw_irq     <= '0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);

        check_reset_state();
        write_then_read();
        exchange_masked();
        exception_and_return();
        timer_interrupt();
        trap_drops_write();

        $display("checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== sources.f ====
design/csr_pkg.sv
design/csr_regfile.sv
design/csr_write_arbiter.sv
design/csr_access_unit.sv
design/excp_unit.sv
design/csr_timer.sv
design/csr_unit.sv
verification/clk_gen.sv
verification/csr_unit_tb.sv
